// File: hdl/icache.sv
module icache (
    input  logic                  clk,
    input  logic                  reset,
    // CPU side
    input  logic                  valid,
    input  logic                  flush,
    input  icache_pkg::addr_t     pc_in,
    input  icache_pkg::addr_t     p_addr,
    input  icache_pkg::cookie_t   cookie_in,
    output logic                  data_valid,
    output icache_pkg::dword_t    r_data_cpu,
    output icache_pkg::addr_t     pc_out,
    output icache_pkg::cookie_t   cookie_out,
    output logic                  cache_ready,
    // memory side
    output logic                  r_req,
    output logic                  r_data_ready,
    output icache_pkg::addr_t     r_addr,
    input  logic                  r_rdy,
    input  logic                  ret_valid,
    input  logic                  ret_last,
    input  logic [31:0]           r_data_axi,
    output icache_pkg::exc_code_e exception
);

    icache_pkg::addr_t    pc_q;        // request buffer
    icache_pkg::cookie_t  cookie_q;
    icache_pkg::addr_t    paddr_q;     // physical buffer
    icache_pkg::way_vec_t miss_way;    // miss-way buffer
    logic                 req_valid;

    logic                 rbuf_we;
    logic                 pbuf_we;
    logic                 mbuf_we;
    logic                 plru_en;
    logic                 rdata_sel;
    logic                 ctrl_data_valid;
    logic                 fill_done;
    icache_pkg::way_vec_t mem_we;
    icache_pkg::way_vec_t tagv_we;
    icache_pkg::way_vec_t plru_way;
    icache_pkg::way_vec_t hit;
    icache_pkg::way_vec_t valid_ways;
    icache_pkg::way_vec_t victim;
    icache_pkg::line_t    fill_line;
    icache_pkg::index_t   rd_index;
    icache_pkg::index_t   buf_index;

    assign rd_index  = pc_in[icache_pkg::OFFSET_BITS +: icache_pkg::INDEX_BITS];
    assign buf_index = paddr_q[icache_pkg::OFFSET_BITS +: icache_pkg::INDEX_BITS];

    always_ff @(posedge clk) begin
        if (rbuf_we) begin
            pc_q     <= pc_in;
            cookie_q <= cookie_in;
        end
        if (pbuf_we)
            paddr_q <= p_addr;
        if (mbuf_we)
            miss_way <= victim;     // victim frozen for the whole refill
    end

    // answer is cancelled by flush, the refill itself carries on
    always_ff @(posedge clk) begin
        if (reset)
            req_valid <= 1'b0;
        else if (flush)
            req_valid <= 1'b0;
        else if (rbuf_we)
            req_valid <= 1'b1;
    end

    assign data_valid = ctrl_data_valid & req_valid & ~flush;
    assign pc_out     = pc_q;
    assign cookie_out = cookie_q;
    assign r_addr     = {paddr_q[31:icache_pkg::OFFSET_BITS], {icache_pkg::OFFSET_BITS{1'b0}}};
    assign exception  = (pc_q[1:0] != 2'b00) ? icache_pkg::EXC_FETCH_MISALIGNED
                                             : icache_pkg::EXC_NONE;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .valid        (valid),
        .hit          (hit),
        .fill_done    (fill_done),
        .r_rdy        (r_rdy),
        .victim       (miss_way),
        .rbuf_we      (rbuf_we),
        .pbuf_we      (pbuf_we),
        .mbuf_we      (mbuf_we),
        .mem_we       (mem_we),
        .tagv_we      (tagv_we),
        .plru_en      (plru_en),
        .plru_way     (plru_way),
        .rdata_sel    (rdata_sel),
        .r_req        (r_req),
        .r_data_ready (r_data_ready),
        .data_valid   (ctrl_data_valid),
        .cache_ready  (cache_ready)
    );

    icache_tagv u_tagv (
        .clk        (clk),
        .reset      (reset),
        .rd_index   (rd_index),
        .wr_index   (buf_index),
        .tag        (paddr_q[31:32-icache_pkg::TAG_BITS]),
        .we         (tagv_we),
        .hit        (hit),
        .valid_ways (valid_ways)
    );

    icache_data u_data (
        .clk       (clk),
        .rd_index  (rd_index),
        .wr_index  (buf_index),
        .offset    (pc_q[icache_pkg::OFFSET_BITS-1:3]),
        .we        (mem_we),
        .fill_line (fill_line),
        .hit       (hit),
        .rdata_sel (rdata_sel),
        .rdata     (r_data_cpu)
    );

    icache_refill_buf u_refill_buf (
        .clk       (clk),
        .reset     (reset),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .beat      (r_data_axi),
        .fill_line (fill_line),
        .fill_done (fill_done)
    );

    icache_plru u_plru (
        .clk        (clk),
        .reset      (reset),
        .index      (buf_index),
        .en         (plru_en),
        .way        (plru_way),
        .valid_ways (valid_ways),
        .victim     (victim)
    );

endmodule

// File: hdl/icache_ctrl.sv
module icache_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  icache_pkg::way_vec_t hit,
    input  logic                 fill_done,
    input  logic                 r_rdy,
    input  icache_pkg::way_vec_t victim,     // recorded victim from the miss buffer
    output logic                 rbuf_we,
    output logic                 pbuf_we,
    output logic                 mbuf_we,
    output icache_pkg::way_vec_t mem_we,
    output icache_pkg::way_vec_t tagv_we,
    output logic                 plru_en,
    output icache_pkg::way_vec_t plru_way,
    output logic                 rdata_sel,
    output logic                 r_req,
    output logic                 r_data_ready,
    output logic                 data_valid,
    output logic                 cache_ready
);

    icache_pkg::ctrl_state_e state;
    icache_pkg::ctrl_state_e state_next;
    logic                    pending;        // request accepted at the last edge
    logic                    lookup_hit;
    logic                    lookup_miss;

    assign lookup_hit  = pending && (hit != '0);
    assign lookup_miss = pending && (hit == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= icache_pkg::IDLE;
            pending <= 1'b0;
        end else begin
            state   <= state_next;
            pending <= valid && cache_ready;
        end
    end

    always_comb begin
        state_next   = state;
        mbuf_we      = 1'b0;
        mem_we       = '0;
        tagv_we      = '0;
        plru_en      = 1'b0;
        plru_way     = '0;
        rdata_sel    = 1'b0;
        r_req        = 1'b0;
        r_data_ready = 1'b0;
        data_valid   = 1'b0;
        cache_ready  = 1'b0;
        case (state)
            icache_pkg::IDLE: begin
                if (lookup_miss) begin
                    r_req   = 1'b1;          // request goes out in the miss cycle
                    mbuf_we = 1'b1;
                    if (r_rdy)
                        state_next = icache_pkg::REFILL;
                    else
                        state_next = icache_pkg::MISS_REQ;
                end else begin
                    cache_ready = 1'b1;
                    if (lookup_hit) begin
                        data_valid = 1'b1;
                        plru_en    = 1'b1;
                        plru_way   = hit;
                    end
                end
            end
            icache_pkg::MISS_REQ: begin
                r_req = 1'b1;                // held until the handshake
                if (r_rdy)
                    state_next = icache_pkg::REFILL;
            end
            icache_pkg::REFILL: begin
                r_data_ready = 1'b1;
                if (fill_done)
                    state_next = icache_pkg::WRITE;
            end
            icache_pkg::WRITE: begin
                mem_we     = victim;
                tagv_we    = victim;
                state_next = icache_pkg::REPLY;
            end
            icache_pkg::REPLY: begin
                data_valid  = 1'b1;
                rdata_sel   = 1'b1;          // data straight from the refill line
                plru_en     = 1'b1;
                plru_way    = victim;
                cache_ready = 1'b1;
                state_next  = icache_pkg::IDLE;
            end
            default: begin
                state_next = icache_pkg::IDLE;
            end
        endcase
    end

    // request and physical buffers load together on acceptance
    assign rbuf_we = valid && cache_ready;
    assign pbuf_we = valid && cache_ready;

    // victim comes through the miss buffer from the PLRU, must stay a single way
    a_mem_we_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(mem_we))
        else $error("line write hits more than one way");

    a_req_not_in_refill: assert property (@(posedge clk) disable iff (reset)
        !(r_req && r_data_ready))
        else $error("r_req raised while beats are expected");

    a_no_answer_in_miss: assert property (@(posedge clk) disable iff (reset)
        data_valid |-> !(state inside {icache_pkg::MISS_REQ, icache_pkg::REFILL}))
        else $error("data_valid while a miss is outstanding");

endmodule

// File: hdl/icache_data.sv
module icache_data (
    input  logic                 clk,
    input  icache_pkg::index_t   rd_index,
    input  icache_pkg::index_t   wr_index,
    input  logic [2:0]           offset,      // doubleword within the line
    input  icache_pkg::way_vec_t we,
    input  icache_pkg::line_t    fill_line,
    input  icache_pkg::way_vec_t hit,
    input  logic                 rdata_sel,
    output icache_pkg::dword_t   rdata
);

    icache_pkg::line_t line_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
    icache_pkg::line_t line_q   [icache_pkg::NUM_WAYS];
    icache_pkg::line_t sel_line;

    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (we[w])
                line_mem[w][wr_index] <= fill_line;
            line_q[w] <= line_mem[w][rd_index];
        end
    end

    // and-or mux over the one-hot hit vector
    always_comb begin
        sel_line = '0;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (hit[w])
                sel_line = sel_line | line_q[w];
        end
        if (rdata_sel)
            sel_line = fill_line;   // reply after refill
    end

    assign rdata = sel_line[offset*64 +: 64];

endmodule

// File: hdl/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 64;
    localparam int LINE_BYTES     = 64;
    localparam int BEATS_PER_LINE = 16;   // 32-bit beats per refill
    localparam int INDEX_BITS     = 6;
    localparam int OFFSET_BITS    = 6;
    localparam int TAG_BITS       = 20;   // physical bits 31..12
    localparam int COOKIE_BITS    = 32;   // opaque, echoed back to the CPU

    typedef logic [31:0]               addr_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [INDEX_BITS-1:0]     index_t;
    typedef logic [NUM_WAYS-1:0]       way_vec_t;
    typedef logic [LINE_BYTES*8-1:0]   line_t;    // word 0 in the low bits
    typedef logic [63:0]               dword_t;
    typedef logic [COOKIE_BITS-1:0]    cookie_t;

    // [0] root, [1] pair 0/1, [2] pair 2/3
    typedef logic [NUM_WAYS-2:0]       plru_t;

    typedef enum logic [2:0] {
        IDLE,       // lookup of the buffered request
        MISS_REQ,   // line request held until r_rdy
        REFILL,     // beats coming back
        WRITE,      // line and tag written into the victim way
        REPLY       // answer from the refill line
    } ctrl_state_e;

    typedef enum logic [6:0] {
        EXC_NONE             = 7'd0,
        EXC_FETCH_MISALIGNED = 7'd4
    } exc_code_e;

endpackage

// File: hdl/icache_plru.sv
module icache_plru (
    input  logic                 clk,
    input  logic                 reset,
    input  icache_pkg::index_t   index,
    input  logic                 en,
    input  icache_pkg::way_vec_t way,          // accessed way, one-hot
    input  icache_pkg::way_vec_t valid_ways,
    output icache_pkg::way_vec_t victim
);

    icache_pkg::plru_t    tree [icache_pkg::NUM_SETS];
    icache_pkg::plru_t    cur;
    icache_pkg::plru_t    upd;
    icache_pkg::way_vec_t invalid_ways;

    assign cur          = tree[index];
    assign invalid_ways = ~valid_ways;

    // bits point away from the way just used
    always_comb begin
        upd = cur;
        if (way[0] || way[1]) begin
            upd[0] = 1'b1;
            upd[1] = way[0];
        end else if (way[2] || way[3]) begin
            upd[0] = 1'b0;
            upd[2] = way[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < icache_pkg::NUM_SETS; s++)
                tree[s] <= '0;
        end else if (en) begin
            tree[index] <= upd;
        end
    end

    always_comb begin
        if (invalid_ways != '0)
            victim = invalid_ways & (~invalid_ways + 1'b1);   // lowest invalid way
        else if (cur[0])
            victim = cur[2] ? 4'b1000 : 4'b0100;
        else
            victim = cur[1] ? 4'b0010 : 4'b0001;
    end

endmodule

// File: hdl/icache_refill_buf.sv
module icache_refill_buf (
    input  logic              clk,
    input  logic              reset,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  logic [31:0]       beat,
    output icache_pkg::line_t fill_line,
    output logic              fill_done
);

    logic [$clog2(icache_pkg::BEATS_PER_LINE)-1:0] beat_cnt;

    // beats shift in from the top, first beat ends up as word 0
    always_ff @(posedge clk) begin
        if (ret_valid)
            fill_line <= {beat, fill_line[icache_pkg::LINE_BYTES*8-1:32]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt  <= '0;
            fill_done <= 1'b0;
        end else begin
            fill_done <= ret_valid && ret_last;
            if (ret_valid)
                beat_cnt <= ret_last ? '0 : beat_cnt + 1'b1;
        end
    end

    a_last_on_final_beat: assert property (@(posedge clk) disable iff (reset)
        ret_valid |-> (ret_last == (beat_cnt == icache_pkg::BEATS_PER_LINE - 1)))
        else $error("ret_last out of step with the beat count");

endmodule

// File: hdl/icache_tagv.sv
module icache_tagv (
    input  logic                 clk,
    input  logic                 reset,
    input  icache_pkg::index_t   rd_index,
    input  icache_pkg::index_t   wr_index,
    input  icache_pkg::tag_t     tag,         // buffered physical tag
    input  icache_pkg::way_vec_t we,
    output icache_pkg::way_vec_t hit,
    output icache_pkg::way_vec_t valid_ways
);

    icache_pkg::tag_t     tag_mem   [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
    icache_pkg::way_vec_t valid_mem [icache_pkg::NUM_SETS];
    icache_pkg::tag_t     tag_q     [icache_pkg::NUM_WAYS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (we[w])
                tag_mem[w][wr_index] <= tag;
            tag_q[w] <= tag_mem[w][rd_index];   // sync read, compared next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < icache_pkg::NUM_SETS; s++)
                valid_mem[s] <= '0;
            valid_ways <= '0;
        end else begin
            valid_mem[wr_index] <= valid_mem[wr_index] | we;
            valid_ways          <= valid_mem[rd_index];
        end
    end

    always_comb begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
            hit[w] = valid_ways[w] && (tag_q[w] == tag);
    end

    // a line is only filled after a miss in its set, so a tag never sits in two ways
    a_hit_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(hit))
        else $error("tag found in more than one way");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the icache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module tb_icache -f src.f -o tb_icache \
    && ./obj_dir/tb_icache > sim.log 2>&1 \
    || { echo "simulation did not build or run"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^NO ERRORS$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: src.f
hdl/icache_pkg.sv
hdl/icache_ctrl.sv
hdl/icache_tagv.sv
hdl/icache_data.sv
hdl/icache_refill_buf.sv
hdl/icache_plru.sv
hdl/icache.sv
tests/tb_icache.sv

// File: tests/icache_testdata.txt
// pc p_addr cookie flush_next_cycle expect_refill expect_exception
// all hex, one fetch request per line
00001000 00001000 c0de0001 0 1 0
00001008 00001008 c0de0002 0 0 0
00001038 00001038 c0de0003 0 0 0
00401040 80001040 c0de0004 0 1 0
00401044 80001044 c0de0005 0 0 0
00401042 80001042 c0de0006 0 0 4
00010140 00010140 c0de0007 0 1 0
00011148 00011148 c0de0008 0 1 0
00012150 00012150 c0de0009 0 1 0
00013158 00013158 c0de000a 0 1 0
00010160 00010160 c0de000b 0 0 0
00012168 00012168 c0de000c 0 0 0
00014170 00014170 c0de000d 0 1 0
00010178 00010178 c0de000e 0 0 0
00012140 00012140 c0de000f 0 0 0
00013140 00013140 c0de0010 0 0 0
00014148 00014148 c0de0011 0 0 0
00011140 00011140 c0de0012 0 1 0
00012150 00012150 c0de0013 0 1 0
00020200 00020200 c0de0014 1 1 0
00020208 00020208 c0de0015 0 0 0
00001010 00001010 c0de0016 1 0 0
00001018 00001018 c0de0017 0 0 0
00030302 00030302 c0de0018 0 1 4
00030301 00030301 c0de0019 0 0 4
0003033c 0003033c c0de001a 0 0 0

// File: tests/tb_icache.sv
module tb_icache;

    logic                  clk;
    logic                  reset;
    logic                  valid;
    logic                  flush;
    logic                  data_valid;
    logic                  cache_ready;
    logic                  r_req;
    logic                  r_data_ready;
    logic                  r_rdy;
    logic                  ret_valid;
    logic                  ret_last;
    logic [31:0]           r_data_axi;
    icache_pkg::addr_t     pc_in;
    icache_pkg::addr_t     p_addr;
    icache_pkg::addr_t     pc_out;
    icache_pkg::addr_t     r_addr;
    icache_pkg::cookie_t   cookie_in;
    icache_pkg::cookie_t   cookie_out;
    icache_pkg::dword_t    r_data_cpu;
    icache_pkg::exc_code_e exception;

    logic [31:0]           vec [0:6*64-1];    // six words per request line
    int                    seed = 32'h950b_854d;
    int                    n_req;
    int                    cycles;
    int                    cycle_limit = 1000;
    int                    line_reqs;         // handshakes seen by the memory model
    int                    reqs_done;         // handshakes already booked to a request
    int                    err_data, err_exc, err_echo, err_refill, err_other;
    icache_pkg::addr_t     last_paddr;        // latest accepted physical address

    // answers still owed by the DUT in arrival order
    icache_pkg::dword_t    exp_data [$];
    icache_pkg::exc_code_e exp_exc [$];
    icache_pkg::addr_t     exp_pc [$];
    icache_pkg::cookie_t   exp_cookie [$];
    logic                  exp_refill [$];

    // reference cache state
    icache_pkg::tag_t      model_tag [64][4];
    logic [3:0]            model_valid [64];
    icache_pkg::plru_t     model_tree [64];

    icache u_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] word_at(icache_pkg::addr_t a);
        return {2'b00, a[31:2]} ^ 32'h5a5a_0000;    // memory content rule
    endfunction

    function automatic icache_pkg::dword_t expected_dword(icache_pkg::addr_t pa);
        icache_pkg::addr_t base;
        base = {pa[31:3], 3'b000};
        return {word_at(base + 4), word_at(base)};
    endfunction

    task automatic model_access(input icache_pkg::addr_t pa, output logic miss);
        int idx;
        int way;
        icache_pkg::plru_t t;
        idx = pa[11:6];
        way = -1;
        t = model_tree[idx];
        for (int w = 0; w < 4; w++)
            if (model_valid[idx][w] && model_tag[idx][w] == pa[31:12])
                way = w;
        miss = (way < 0);
        if (miss) begin
            for (int w = 3; w >= 0; w--)
                if (!model_valid[idx][w])
                    way = w;                          // lowest empty way first
            if (way < 0)
                way = t[0] ? (t[2] ? 3 : 2) : (t[1] ? 1 : 0);
            model_tag[idx][way]   = pa[31:12];
            model_valid[idx][way] = 1'b1;
        end
        // tree now points away from the way just used
        t[0] = (way < 2);
        if (way < 2)
            t[1] = (way == 0);
        else
            t[2] = (way == 2);
        model_tree[idx] = t;
    endtask

    task automatic check_data(icache_pkg::dword_t got, icache_pkg::dword_t exp);
        if (got !== exp) begin
            err_data++;
            $display("FAILED @%0t: r_data_cpu %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_exc(icache_pkg::exc_code_e got, icache_pkg::exc_code_e exp);
        if (got !== exp) begin
            err_exc++;
            $display("FAILED @%0t: exception %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_echo(icache_pkg::addr_t got_pc, icache_pkg::addr_t exp_pc_v,
                              icache_pkg::cookie_t got_ck, icache_pkg::cookie_t exp_ck);
        if (got_pc !== exp_pc_v || got_ck !== exp_ck) begin
            err_echo++;
            $display("FAILED @%0t: echo pc %h cookie %h, expected pc %h cookie %h",
                     $time, got_pc, got_ck, exp_pc_v, exp_ck);
        end
    endtask

    task automatic check_refill(logic exp, int seen);
        if (seen != (exp ? 1 : 0)) begin
            err_refill++;
            $display("FAILED @%0t: %0d line requests, expected %0d", $time, seen, exp);
        end
    endtask

    task automatic check_line_addr(icache_pkg::addr_t got, icache_pkg::addr_t exp);
        if (got !== exp) begin
            err_refill++;
            $display("FAILED @%0t: r_addr %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_data_ready(logic got, logic exp);
        if (got !== exp) begin
            err_refill++;
            $display("FAILED @%0t: r_data_ready %b, expected %b", $time, got, exp);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("simulation stopped after %0d cycles, %0d answers never arrived",
                     cycles, exp_data.size());
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // answer monitor samples on the falling edge
    always @(negedge clk) begin
        if (!reset && data_valid) begin
            if (exp_data.size() == 0) begin
                err_other++;
                $display("data_valid at %0t with no request waiting for an answer", $time);
            end else begin
                check_data(r_data_cpu, exp_data.pop_front());
                check_exc(exception, exp_exc.pop_front());
                check_echo(pc_out, exp_pc.pop_front(), cookie_out, exp_cookie.pop_front());
                check_refill(exp_refill.pop_front(), line_reqs - reqs_done);
                reqs_done = line_reqs;
            end
        end
    end

    // memory model with random r_rdy delay and random gaps between beats
    initial begin
        int delay;
        icache_pkg::addr_t line_addr;
        r_rdy      = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        r_data_axi = '0;
        forever begin
            @(negedge clk);
            if (!reset && r_req && r_rdy) begin
                check_line_addr(r_addr, {last_paddr[31:6], 6'b0});
                check_data_ready(r_data_ready, 1'b0);
                line_addr = r_addr;
                line_reqs++;
                @(posedge clk);                      // handshake edge
                #1 r_rdy = 1'b0;
                for (int b = 0; b < 16; b++) begin
                    if (($random(seed) & 3) == 0) begin
                        ret_valid = 1'b0;            // gap cycle
                        @(posedge clk);
                        #1;
                    end
                    ret_valid  = 1'b1;
                    ret_last   = (b == 15);
                    r_data_axi = word_at(line_addr + b * 4);
                    check_data_ready(r_data_ready, 1'b1);
                    @(posedge clk);
                    #1;
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
                r_rdy     = ($random(seed) & 1) != 0;  // sometimes ready ahead of the miss
            end else if (!reset && r_req) begin
                delay = $random(seed) & 3;
                repeat (delay + 1) @(posedge clk);
                #1 r_rdy = 1'b1;
            end
        end
    end

    initial begin
        logic miss;
        int k;
        clk       = 1'b0;
        reset     = 1'b1;
        valid     = 1'b0;
        flush     = 1'b0;
        pc_in     = '0;
        p_addr    = '0;
        cookie_in = '0;
        for (int s = 0; s < 64; s++) begin
            model_valid[s] = '0;
            model_tree[s]  = '0;
        end
        for (int i = 0; i < 6 * 64; i++)
            vec[i] = '1;                             // all ones marks the end
        $readmemh("tests/icache_testdata.txt", vec);
        n_req = 0;
        while (n_req < 64 && vec[n_req * 6 + 3] != 32'hffff_ffff)
            n_req++;
        cycle_limit = n_req * 60;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < n_req; i++) begin
            k         = i * 6;
            valid     = 1'b1;
            pc_in     = vec[k];
            p_addr    = vec[k + 1];
            cookie_in = vec[k + 2];
            do
                @(negedge clk);
            while (!cache_ready);
            @(posedge clk);                          // request taken here
            last_paddr = p_addr;
            model_access(p_addr, miss);
            if (miss != vec[k + 4][0]) begin
                err_other++;
                $display("reference model and data file disagree on a miss for request %0d", i);
            end
            if (!vec[k + 3][0]) begin
                exp_data.push_back(expected_dword(p_addr));
                exp_exc.push_back(icache_pkg::exc_code_e'(vec[k + 5][6:0]));
                exp_pc.push_back(pc_in);
                exp_cookie.push_back(cookie_in);
                exp_refill.push_back(vec[k + 4][0]);
            end
            #1 valid = 1'b0;
            if (vec[k + 3][0]) begin
                flush = 1'b1;                        // cancel during the lookup cycle
                @(posedge clk);
                #1 flush = 1'b0;
                do
                    @(negedge clk);
                while (!cache_ready);
                check_refill(vec[k + 4][0], line_reqs - reqs_done);
                reqs_done = line_reqs;
                @(posedge clk);
                #1;
            end
        end
        while (exp_data.size() != 0)
            @(negedge clk);
        repeat (4) @(negedge clk);
        $display("errors: data %0d, exception %0d, echo %0d, refill %0d, other %0d",
                 err_data, err_exc, err_echo, err_refill, err_other);
        if (err_data + err_exc + err_echo + err_refill + err_other == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
